// File: dv/mem_endpoint_tb.sv
// Directed testbench that drives the memory endpoint top level and checks every reply against a reference memory model
`default_nettype none

`include "mem_endpoint_macros.svh"

module mem_endpoint_tb
  import mem_endpoint_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  // Cycle budget per test where a request costs at most three cycles
  localparam int limit_test_cycles_lp  = 3 * (`RET_CREDITS + 2) + 30;
  localparam int word_test_cycles_lp   = 3 * 32;
  localparam int masked_test_cycles_lp = 3 * 32;
  localparam int packed_test_cycles_lp = 3 * 34;
  localparam int atomic_test_cycles_lp = 3 * 9;
  localparam int timeout_cycles_lp = 2 * (2 * limit_test_cycles_lp + word_test_cycles_lp +
    masked_test_cycles_lp + packed_test_cycles_lp + atomic_test_cycles_lp) + 100;

  logic                       clk_i;
  logic                       reset_i;
  logic                       req_v_i;
  mem_op_e                    req_op_i;
  logic [`MEM_ADDR_WIDTH-1:0] req_addr_i;
  req_payload_u               req_payload_i;
  logic [`MEM_MASK_WIDTH-1:0] req_mask_i;
  logic [`REG_ID_WIDTH-1:0]   req_reg_id_i;
  logic [`SRC_ID_WIDTH-1:0]   req_src_i;
  logic                       req_yumi_o;
  logic                       ret_v_o;
  ret_type_e                  ret_type_o;
  logic [`MEM_DATA_WIDTH-1:0] ret_data_o;
  logic [`REG_ID_WIDTH-1:0]   ret_reg_id_o;
  logic [`SRC_ID_WIDTH-1:0]   ret_dst_o;
  logic                       ret_credit_i;

  logic [`MEM_DATA_WIDTH-1:0] model_mem [`MEM_ELS];
  logic [`MEM_ADDR_WIDTH-1:0] addr_list [16];
  logic [31:0]                lfsr_state;

  ret_type_e                  exp_type_q[$];
  ret_type_e                  got_type_q[$];
  logic [`MEM_DATA_WIDTH-1:0] exp_data_q[$];
  logic [`MEM_DATA_WIDTH-1:0] got_data_q[$];
  logic [31:0]                exp_reg_q[$];
  logic [31:0]                got_reg_q[$];
  logic [31:0]                exp_dst_q[$];
  logic [31:0]                got_dst_q[$];

  logic auto_credit = 1'b1;  // Hand back a credit for every reply seen
  int   grants_allowed = 0;
  int   credits_given = 0;
  int   replies_seen = 0;
  int   error_count = 0;
  int   cycle_count = 0;

  mem_endpoint_top dut_i (.*);

  always #5 clk_i = ~clk_i;

  // Reply collector
  always @(posedge clk_i) begin
    if (!reset_i && ret_v_o) begin
      got_type_q.push_back(ret_type_o);
      got_data_q.push_back(ret_data_o);
      got_reg_q.push_back(32'(ret_reg_id_o));
      got_dst_q.push_back(32'(ret_dst_o));
      replies_seen++;
    end
  end

  // Downstream side returns at most one credit per cycle
  always @(negedge clk_i) begin
    if (!reset_i && credits_given < replies_seen && (auto_credit || grants_allowed > 0)) begin
      ret_credit_i = 1'b1;
      credits_given++;
      if (!auto_credit) grants_allowed--;
    end else begin
      ret_credit_i = 1'b0;
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > timeout_cycles_lp) abort_run("Run exceeded its cycle limit");
  end

  task automatic abort_run(input string why);
    error_count++;
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [`MEM_DATA_WIDTH-1:0] expected,
                            input logic [`MEM_DATA_WIDTH-1:0] actual);
    if (actual !== expected)
      abort_run($sformatf("CHECK FAILED at time %0t: %s expected %h got %h",
                          $time, name, expected, actual));
  endtask

  task automatic check_ret_type(input string name, input ret_type_e expected,
                                input ret_type_e actual);
    if (actual !== expected)
      abort_run($sformatf("CHECK FAILED at time %0t: %s expected %s got %s",
                          $time, name, expected.name(), actual.name()));
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      abort_run($sformatf("CHECK FAILED at time %0t: %s expected %b got %b",
                          $time, name, expected, actual));
  endtask

  // Fibonacci LFSR with taps 32 22 2 and 1 stepped once per bit
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [`MEM_DATA_WIDTH-1:0] expected_load(
      input logic [`MEM_DATA_WIDTH-1:0] word, input load_info_s info);
    logic [`MEM_DATA_WIDTH-1:0] lane;
    if (info.is_byte) begin
      lane = (word >> (8 * info.part_sel)) & 32'h0000_00ff;
      return (lane[7] && !info.is_unsigned) ? (lane | 32'hffff_ff00) : lane;
    end
    if (info.is_half) begin
      lane = (word >> (info.part_sel[1] ? 16 : 0)) & 32'h0000_ffff;
      return (lane[15] && !info.is_unsigned) ? (lane | 32'hffff_0000) : lane;
    end
    return word;
  endfunction

  // Puts a request on the inputs and records the reply the model predicts
  task automatic drive_req(input mem_op_e op, input logic [`MEM_ADDR_WIDTH-1:0] addr,
                           input req_payload_u payload, input logic [`MEM_MASK_WIDTH-1:0] mask);
    logic [`MEM_DATA_WIDTH-1:0] old_word;
    logic [`MEM_DATA_WIDTH-1:0] edata;
    logic [31:0]                ids;
    ret_type_e                  etype;
    old_word = model_mem[addr];
    ids = next_bits(`REG_ID_WIDTH + `SRC_ID_WIDTH);
    etype = e_ret_credit;
    edata = '0;
    case (op)
      e_load: begin
        etype = payload.load_info.float_wb ? e_ret_float_wb : e_ret_int_wb;
        edata = expected_load(old_word, payload.load_info);
      end
      e_store: begin
        for (int b = 0; b < `MEM_MASK_WIDTH; b++)
          if (mask[b]) model_mem[addr][8*b +: 8] = payload.store_data[8*b +: 8];
      end
      e_store_word: model_mem[addr] = payload.store_data;
      e_amo_swap, e_amo_or, e_amo_add: begin
        etype = e_ret_int_wb;
        edata = old_word;  // Atomics hand back the word they replaced
        model_mem[addr] = (op == e_amo_or) ? (old_word | payload.store_data) :
                          (op == e_amo_add) ? (old_word + payload.store_data) :
                          payload.store_data;
      end
      default: abort_run("Test requested an opcode the endpoint does not serve");
    endcase
    exp_type_q.push_back(etype);
    exp_data_q.push_back(edata);
    exp_reg_q.push_back(32'(ids[`REG_ID_WIDTH-1:0]));
    exp_dst_q.push_back(32'(ids[`REG_ID_WIDTH +: `SRC_ID_WIDTH]));
    req_v_i = 1'b1;
    req_op_i = op;
    req_addr_i = addr;
    req_payload_i = payload;
    req_mask_i = mask;
    req_reg_id_i = ids[`REG_ID_WIDTH-1:0];
    req_src_i = ids[`REG_ID_WIDTH +: `SRC_ID_WIDTH];
  endtask

  task automatic wait_accept();
    int waited;
    waited = 0;
    @(posedge clk_i);
    while (!req_yumi_o) begin
      waited++;
      if (waited > 64) abort_run("Request was never accepted");
      @(posedge clk_i);
    end
    @(negedge clk_i);
    req_v_i = 1'b0;
  endtask

  task automatic send_req(input mem_op_e op, input logic [`MEM_ADDR_WIDTH-1:0] addr,
                          input req_payload_u payload, input logic [`MEM_MASK_WIDTH-1:0] mask);
    drive_req(op, addr, payload, mask);
    wait_accept();
  endtask

  // Waits for every predicted reply, then compares them in request order
  task automatic wait_replies();
    int waited;
    waited = 0;
    while (got_data_q.size() < exp_data_q.size()) begin
      @(negedge clk_i);
      waited++;
      if (waited > 100) abort_run("Expected replies did not arrive");
    end
    if (got_data_q.size() > exp_data_q.size()) abort_run("More replies than requests");
    while (exp_data_q.size() > 0) begin
      check_ret_type("ret_type_o", exp_type_q.pop_front(), got_type_q.pop_front());
      check_word("ret_data_o", exp_data_q.pop_front(), got_data_q.pop_front());
      check_word("ret_reg_id_o", exp_reg_q.pop_front(), got_reg_q.pop_front());
      check_word("ret_dst_o", exp_dst_q.pop_front(), got_dst_q.pop_front());
    end
  endtask

  task automatic hold_blocked(input int cycles);
    repeat (cycles) begin
      @(posedge clk_i);
      check_bit("req_yumi_o", 1'b0, req_yumi_o);
      check_bit("ret_v_o", 1'b0, ret_v_o);
    end
    @(negedge clk_i);
  endtask

  task automatic grant_credit();
    @(posedge clk_i);
    grants_allowed++;
  endtask

  // Spends every credit, leaves one reply pending and one request waiting, then frees them
  task automatic stall_and_release(input mem_op_e op);
    req_payload_u p;
    logic [31:0]  r;
    repeat (`RET_CREDITS + 2) @(negedge clk_i);  // Let earlier credits come home
    auto_credit = 1'b0;
    for (int i = 0; i < `RET_CREDITS + 2; i++) begin
      r = (op == e_load) ? next_bits(1) : next_bits(32);
      p.store_data = (op == e_load) ? {r[0], 31'b0} : r;
      drive_req(op, addr_list[i], p, '1);
      if (i < `RET_CREDITS + 1) wait_accept();
    end
    hold_blocked(8);
    check_word("reply count", 32'(exp_data_q.size() - 2), 32'(got_data_q.size()));
    grant_credit();
    wait_accept();
    hold_blocked(4);
    check_word("reply count", 32'(exp_data_q.size() - 1), 32'(got_data_q.size()));
    grant_credit();
    wait_replies();
    auto_credit = 1'b1;
  endtask

  task automatic reset_and_credit_limit();
    check_bit("ret_v_o", 1'b0, ret_v_o);
    stall_and_release(e_store_word);
  endtask

  task automatic word_traffic();
    req_payload_u p;
    logic [31:0]  r;
    for (int i = 0; i < 16; i++) begin
      p.store_data = next_bits(32);
      send_req(e_store_word, addr_list[i], p, '1);
    end
    for (int i = 0; i < 16; i++) begin
      r = next_bits(1);
      p.store_data = {r[0], 31'b0};  // Word load with a random float_wb
      send_req(e_load, addr_list[i], p, '0);
    end
    wait_replies();
  endtask

  task automatic masked_stores();
    req_payload_u               p;
    logic [`MEM_MASK_WIDTH-1:0] m;
    logic [31:0]                r;
    for (int i = 0; i < 16; i++) begin
      r = next_bits(`MEM_MASK_WIDTH);
      m = (r[`MEM_MASK_WIDTH-1:0] == '0) ? 4'b0001 : r[`MEM_MASK_WIDTH-1:0];
      p.store_data = next_bits(32);
      send_req(e_store, addr_list[i], p, m);
      p.store_data = '0;
      send_req(e_load, addr_list[i], p, '0);
    end
    wait_replies();
  endtask

  task automatic packed_loads();
    req_payload_u p;
    load_info_s   info;
    p.store_data = next_bits(32) | 32'h8080_8080;  // Every lane negative
    send_req(e_store_word, addr_list[0], p, '1);
    p.store_data = next_bits(32) & 32'h7f7f_7f7f;
    send_req(e_store_word, addr_list[1], p, '1);
    for (int w = 0; w < 2; w++)
      for (int part = 0; part < 4; part++)
        for (int u = 0; u < 4; u++) begin
          info = '0;
          info.is_unsigned = u[0];
          info.is_half = u[1];
          info.is_byte = !u[1];
          info.part_sel = part[1:0];
          p.load_info = info;
          send_req(e_load, addr_list[w], p, '0);
        end
    wait_replies();
  endtask

  task automatic atomic_ops();
    req_payload_u p;
    mem_op_e      op;
    for (int i = 0; i < 3; i++) begin
      op = (i == 0) ? e_amo_swap : (i == 1) ? e_amo_or : e_amo_add;
      p.store_data = next_bits(32);
      send_req(e_store_word, addr_list[i + 2], p, '1);
      p.store_data = next_bits(32);
      send_req(op, addr_list[i + 2], p, '1);
      p.store_data = '0;
      send_req(e_load, addr_list[i + 2], p, '0);
    end
    wait_replies();
  endtask

  initial begin
    logic [31:0] r;
    clk_i = 1'b0;
    reset_i = 1'b1;
    req_v_i = 1'b0;
    req_op_i = e_load;
    req_addr_i = '0;
    req_payload_i = '0;
    req_mask_i = '0;
    req_reg_id_i = '0;
    req_src_i = '0;
    ret_credit_i = 1'b0;
    lfsr_state = 32'd67519;
    for (int i = 0; i < 16; i++) begin
      r = next_bits(`MEM_ADDR_WIDTH);
      addr_list[i] = r[`MEM_ADDR_WIDTH-1:0];
    end
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;
    reset_and_credit_limit();
    word_traffic();
    masked_stores();
    packed_loads();
    atomic_ops();
    stall_and_release(e_load);  // Loads of the words left by the earlier tests
    if (error_count == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("*** FAILED ***");
      $fatal(1, "errors were recorded");
    end
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
verilog/mem_endpoint_pkg.sv
verilog/mem_byte_array.sv
verilog/load_packer.sv
verilog/return_credit_counter.sv
verilog/mem_endpoint_fsm.sv
verilog/mem_endpoint_top.sv
dv/mem_endpoint_tb.sv

// File: include/mem_endpoint_macros.svh
// Width, depth and credit constants for the memory endpoint, included by each source file
`ifndef MEM_ENDPOINT_MACROS_SVH
`define MEM_ENDPOINT_MACROS_SVH

// Data word and byte lanes
`define MEM_DATA_WIDTH 32
`define MEM_MASK_WIDTH 4

// Array depth in words and the matching word address width
`define MEM_ELS 1024
`define MEM_ADDR_WIDTH 10

// Requester and destination register identifiers
`define SRC_ID_WIDTH 6
`define REG_ID_WIDTH 5

// Return packets the downstream side can absorb after reset
`define RET_CREDITS 4

`endif

// File: run_sim.sh
#!/bin/sh
# Builds the memory endpoint testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module mem_endpoint_tb -f flist.f -o sim_mem_endpoint

./obj_dir/sim_mem_endpoint > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -qF '*** PASSED ***' sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation finished cleanly"

// File: verilog/load_packer.sv
// Extracts a byte or halfword from a read word and extends it for a sub-word load
`default_nettype none

`include "mem_endpoint_macros.svh"

module load_packer
  import mem_endpoint_pkg::*;
(
  input  logic [`MEM_DATA_WIDTH-1:0] mem_data_i,
  input  load_info_s                 load_info_i,
  output logic [`MEM_DATA_WIDTH-1:0] load_data_o
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  logic        fill;

  assign byte_sel = mem_data_i[8*load_info_i.part_sel +: 8];
  assign half_sel = mem_data_i[16*load_info_i.part_sel[1] +: 16];

  always_comb begin
    fill = 1'b0;
    if (load_info_i.is_byte) begin
      fill = ~load_info_i.is_unsigned & byte_sel[7];
      load_data_o = {{(`MEM_DATA_WIDTH-8){fill}}, byte_sel};
    end else if (load_info_i.is_half) begin
      fill = ~load_info_i.is_unsigned & half_sel[15];
      load_data_o = {{(`MEM_DATA_WIDTH-16){fill}}, half_sel};
    end else begin
      load_data_o = mem_data_i;  // Full word
    end
  end

endmodule

`default_nettype wire

// File: verilog/mem_byte_array.sv
// Synchronous single-port word array with byte write enables, one-cycle read latency
`default_nettype none

`include "mem_endpoint_macros.svh"

module mem_byte_array (
  input  logic                       clk_i,
  input  logic                       v_i,
  input  logic                       w_i,
  input  logic [`MEM_ADDR_WIDTH-1:0] addr_i,
  input  logic [`MEM_DATA_WIDTH-1:0] data_i,
  input  logic [`MEM_MASK_WIDTH-1:0] mask_i,
  output logic [`MEM_DATA_WIDTH-1:0] data_o
);

  logic [`MEM_DATA_WIDTH-1:0] mem_r [`MEM_ELS];

  // Writes touch only the enabled byte lanes
  always_ff @(posedge clk_i) begin
    if (v_i && w_i) begin
      for (int b = 0; b < `MEM_MASK_WIDTH; b++) begin
        if (mask_i[b]) begin
          mem_r[addr_i][8*b +: 8] <= data_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i && !w_i) begin
      data_o <= mem_r[addr_i];  // Output holds across writes and idle cycles
    end
  end

  // The controller must never issue a write that changes nothing
  write_mask_nonzero_a: assert property (
    @(posedge clk_i) (v_i && w_i) |-> (mask_i != '0)
  ) else $error("write issued with an empty byte mask");

endmodule

`default_nettype wire

// File: verilog/mem_endpoint_fsm.sv
// Request controller: accepts one request at a time, drives the array and forms return packets
`default_nettype none

`include "mem_endpoint_macros.svh"

module mem_endpoint_fsm
  import mem_endpoint_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  logic                       req_v_i,
  input  mem_op_e                    req_op_i,
  input  logic [`MEM_ADDR_WIDTH-1:0] req_addr_i,
  input  req_payload_u               req_payload_i,
  input  logic [`MEM_MASK_WIDTH-1:0] req_mask_i,
  input  logic [`REG_ID_WIDTH-1:0]   req_reg_id_i,
  input  logic [`SRC_ID_WIDTH-1:0]   req_src_i,
  output logic                       req_yumi_o,

  output logic                       ret_v_o,
  output ret_type_e                  ret_type_o,
  output logic [`MEM_DATA_WIDTH-1:0] ret_data_o,
  output logic [`REG_ID_WIDTH-1:0]   ret_reg_id_o,
  output logic [`SRC_ID_WIDTH-1:0]   ret_dst_o,

  output logic                       mem_v_o,
  output logic                       mem_w_o,
  output logic [`MEM_ADDR_WIDTH-1:0] mem_addr_o,
  output logic [`MEM_DATA_WIDTH-1:0] mem_wdata_o,
  output logic [`MEM_MASK_WIDTH-1:0] mem_mask_o,
  input  logic [`MEM_DATA_WIDTH-1:0] mem_rdata_i,

  input  logic [`MEM_DATA_WIDTH-1:0] packed_load_i,
  output load_info_s                 load_info_o,
  input  logic                       credit_avail_i
);

  typedef enum logic {
    s_ready,
    s_atomic
  } state_e;

  state_e state_r, state_n;
  logic   pending_r, pending_n;  // A load or store reply still has to go out

  // Request held from acceptance until its reply is sent
  mem_op_e                    op_r;
  logic [`MEM_ADDR_WIDTH-1:0] addr_r;
  req_payload_u               payload_r;
  logic [`REG_ID_WIDTH-1:0]   reg_id_r;
  logic [`SRC_ID_WIDTH-1:0]   src_r;

  logic req_is_amo;
  logic req_is_store;
  logic accept;

  assign req_is_amo   = req_op_i inside {e_amo_swap, e_amo_or, e_amo_add};
  assign req_is_store = req_op_i inside {e_store, e_store_word};

  // A new request may enter when no reply is owed or the owed one leaves now
  assign accept = (state_r == s_ready) && req_v_i && (!pending_r || credit_avail_i);

  assign load_info_o  = payload_r.load_info;
  assign ret_reg_id_o = reg_id_r;
  assign ret_dst_o    = src_r;

  always_comb begin
    req_yumi_o  = 1'b0;
    mem_v_o     = 1'b0;
    mem_w_o     = 1'b0;
    mem_addr_o  = req_addr_i;
    mem_wdata_o = req_payload_i.store_data;
    mem_mask_o  = (req_op_i == e_store) ? req_mask_i : '1;
    ret_v_o     = 1'b0;
    ret_type_o  = e_ret_int_wb;
    ret_data_o  = '0;
    state_n     = state_r;
    pending_n   = pending_r;

    case (state_r)
      s_ready: begin
        req_yumi_o = accept;
        mem_v_o    = accept;
        mem_w_o    = req_is_store;

        if (op_r inside {e_store, e_store_word}) begin
          ret_type_o = e_ret_credit;
        end else begin
          ret_type_o = payload_r.load_info.float_wb ? e_ret_float_wb : e_ret_int_wb;
          ret_data_o = packed_load_i;  // Array still holds the word read at acceptance
        end
        ret_v_o = pending_r && credit_avail_i;

        if (accept) begin
          pending_n = !req_is_amo;
          state_n   = req_is_amo ? s_atomic : s_ready;
        end else if (ret_v_o) begin
          pending_n = 1'b0;
        end
      end

      s_atomic: begin
        // Write back and reply together once a credit is there
        mem_v_o    = credit_avail_i;
        mem_w_o    = credit_avail_i;
        mem_addr_o = addr_r;
        mem_mask_o = '1;
        case (op_r)
          e_amo_or:  mem_wdata_o = payload_r.store_data | mem_rdata_i;
          e_amo_add: mem_wdata_o = payload_r.store_data + mem_rdata_i;
          default:   mem_wdata_o = payload_r.store_data;  // Swap
        endcase
        ret_v_o    = credit_avail_i;
        ret_data_o = mem_rdata_i;  // Old word
        state_n    = credit_avail_i ? s_ready : s_atomic;
      end

      default: state_n = s_ready;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r   <= s_ready;
      pending_r <= 1'b0;
      op_r      <= e_load;
    end else begin
      state_r   <= state_n;
      pending_r <= pending_n;
      if (req_yumi_o) begin
        op_r <= req_op_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_yumi_o) begin
      addr_r    <= req_addr_i;
      payload_r <= req_payload_i;
      reg_id_r  <= req_reg_id_i;
      src_r     <= req_src_i;
    end
  end

  // Cache management requests have no meaning for a flat memory
  no_cache_op_a: assert property (
    @(posedge clk_i) disable iff (reset_i) req_v_i |-> (req_op_i != e_cache_op)
  ) else $error("cache management request sent to memory endpoint");

endmodule

`default_nettype wire

// File: verilog/mem_endpoint_pkg.sv
// Request opcodes, return types and the request payload layout shared by the endpoint modules
`default_nettype none

`include "mem_endpoint_macros.svh"

package mem_endpoint_pkg;

  // Remote request opcodes
  typedef enum logic [2:0] {
    e_load       = 3'd0,
    e_store      = 3'd1,  // Byte-masked store
    e_store_word = 3'd2,
    e_amo_swap   = 3'd3,
    e_amo_or     = 3'd4,
    e_amo_add    = 3'd5,
    e_cache_op   = 3'd6   // Not handled by this endpoint
  } mem_op_e;

  // Kind of return packet
  typedef enum logic [1:0] {
    e_ret_credit   = 2'd0,  // Store acknowledge with no data
    e_ret_int_wb   = 2'd1,
    e_ret_float_wb = 2'd2
  } ret_type_e;

  // How a load request wants its data shaped
  typedef struct packed {
    logic        float_wb;     // Reply goes to the float register file
    logic        is_unsigned;
    logic        is_byte;
    logic        is_half;
    logic [1:0]  part_sel;     // Byte index, upper bit picks the halfword
    logic [`MEM_DATA_WIDTH-7:0] reserved;
  } load_info_s;

  // A request payload is store data for writes and load info for reads
  typedef union packed {
    logic [`MEM_DATA_WIDTH-1:0] store_data;
    load_info_s                 load_info;
  } req_payload_u;

endpackage

`default_nettype wire

// File: verilog/mem_endpoint_top.sv
// Memory endpoint top level: request controller, word array, load packer and return credits
`default_nettype none

`include "mem_endpoint_macros.svh"

module mem_endpoint_top
  import mem_endpoint_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       reset_i,

  input  logic                       req_v_i,
  input  mem_op_e                    req_op_i,
  input  logic [`MEM_ADDR_WIDTH-1:0] req_addr_i,
  input  req_payload_u               req_payload_i,
  input  logic [`MEM_MASK_WIDTH-1:0] req_mask_i,
  input  logic [`REG_ID_WIDTH-1:0]   req_reg_id_i,
  input  logic [`SRC_ID_WIDTH-1:0]   req_src_i,
  output logic                       req_yumi_o,

  output logic                       ret_v_o,
  output ret_type_e                  ret_type_o,
  output logic [`MEM_DATA_WIDTH-1:0] ret_data_o,
  output logic [`REG_ID_WIDTH-1:0]   ret_reg_id_o,
  output logic [`SRC_ID_WIDTH-1:0]   ret_dst_o,
  input  logic                       ret_credit_i
);

  logic                       mem_v;
  logic                       mem_w;
  logic [`MEM_ADDR_WIDTH-1:0] mem_addr;
  logic [`MEM_DATA_WIDTH-1:0] mem_wdata;
  logic [`MEM_MASK_WIDTH-1:0] mem_mask;
  logic [`MEM_DATA_WIDTH-1:0] mem_rdata;
  logic [`MEM_DATA_WIDTH-1:0] packed_load;
  load_info_s                 load_info;
  logic                       credit_avail;

  mem_endpoint_fsm fsm0 (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_v_i        (req_v_i),
    .req_op_i       (req_op_i),
    .req_addr_i     (req_addr_i),
    .req_payload_i  (req_payload_i),
    .req_mask_i     (req_mask_i),
    .req_reg_id_i   (req_reg_id_i),
    .req_src_i      (req_src_i),
    .req_yumi_o     (req_yumi_o),
    .ret_v_o        (ret_v_o),
    .ret_type_o     (ret_type_o),
    .ret_data_o     (ret_data_o),
    .ret_reg_id_o   (ret_reg_id_o),
    .ret_dst_o      (ret_dst_o),
    .mem_v_o        (mem_v),
    .mem_w_o        (mem_w),
    .mem_addr_o     (mem_addr),
    .mem_wdata_o    (mem_wdata),
    .mem_mask_o     (mem_mask),
    .mem_rdata_i    (mem_rdata),
    .packed_load_i  (packed_load),
    .load_info_o    (load_info),
    .credit_avail_i (credit_avail)
  );

  mem_byte_array array0 (
    .clk_i  (clk_i),
    .v_i    (mem_v),
    .w_i    (mem_w),
    .addr_i (mem_addr),
    .data_i (mem_wdata),
    .mask_i (mem_mask),
    .data_o (mem_rdata)
  );

  load_packer packer0 (
    .mem_data_i  (mem_rdata),
    .load_info_i (load_info),
    .load_data_o (packed_load)
  );

  // Every reply strobe spends one credit
  return_credit_counter #(
    .credits_p (`RET_CREDITS)
  ) credit0 (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .credit_i       (ret_credit_i),
    .spend_i        (ret_v_o),
    .credit_avail_o (credit_avail)
  );

endmodule

`default_nettype wire

// File: verilog/return_credit_counter.sv
// Tracks how many return packets downstream can still take, starting full after reset
`default_nettype none

`include "mem_endpoint_macros.svh"

module return_credit_counter #(
  parameter int credits_p = `RET_CREDITS
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic credit_i,
  input  logic spend_i,
  output logic credit_avail_o
);

  localparam int cnt_width_lp = $clog2(credits_p + 1);

  logic [cnt_width_lp-1:0] count_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= cnt_width_lp'(credits_p);
    end else if (credit_i && !spend_i) begin
      count_r <= count_r + 1'b1;
    end else if (spend_i && !credit_i) begin
      count_r <= count_r - 1'b1;
    end
  end

  assign credit_avail_o = (count_r != '0);

  // Downstream may not hand back more credits than it was given
  count_bounded_a: assert property (
    @(posedge clk_i) disable iff (reset_i) count_r <= cnt_width_lp'(credits_p)
  ) else $error("credit count above %0d", credits_p);

  // A reply that goes out with no credit would overrun the receiver
  no_spend_at_zero_a: assert property (
    @(posedge clk_i) disable iff (reset_i) spend_i |-> (count_r != '0)
  ) else $error("reply sent with no credit left");

endmodule

`default_nettype wire
